/* sources.f */
+incdir+common
common/cart_pkg.sv
common/cart_bus_if.sv
cartridge/cart_decoder.sv
cartridge/freeze_control.sv
cartridge/breakpoint_watch.sv
cartridge/register_shadow.sv
source/action_replay_top.sv
test/tb_action_replay.sv

/* test/tb_action_replay.sv */
// directed testbench for the freeze cartridge top level
`timescale 1ns/100ps
`include "cart_consts.svh"

module tb_action_replay;

	// limit set well above the roughly 250 cycles the five tests take
	localparam int TIMEOUT_CYCLES = 2000;

	logic clk;
	logic reset;
	cart_pkg::cpu_addr_t cpu_address;
	logic cpu_as_n;
	logic cpu_rd;
	logic cpu_hwr;
	logic cpu_lwr;
	logic dbr;
	logic boot;
	cart_pkg::word_t data_in;
	logic freeze;
	cart_pkg::reg_addr_t reg_address;
	cart_pkg::word_t reg_data;
	cart_pkg::word_t data_out;
	logic selmem;
	logic ovr;
	logic int7;
	logic aron;

	integer seed;
	int errors;
	int checks;
	int cycles;
	cart_pkg::word_t shadow_exp [16];

	action_replay_top dut (
		.clk(clk), .reset(reset), .cpu_address(cpu_address), .cpu_as_n(cpu_as_n),
		.cpu_rd(cpu_rd), .cpu_hwr(cpu_hwr), .cpu_lwr(cpu_lwr), .dbr(dbr), .boot(boot),
		.data_in(data_in), .freeze(freeze), .reg_address(reg_address),
		.reg_data(reg_data), .data_out(data_out), .selmem(selmem), .ovr(ovr),
		.int7(int7), .aron(aron)
	);

	always #5 clk = ~clk;

	// run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("test failed");
			$finish;
		end
	end

	task automatic check_word(input cart_pkg::word_t actual, input cart_pkg::word_t expected,
			input string what);
		checks++;
		if (actual !== expected) begin
			$display("FAILED at %0t: %s, got %h expected %h", $time, what, actual, expected);
			errors++;
		end
	endtask

	task automatic check_bit(input logic actual, input logic expected, input string what);
		checks++;
		if (actual !== expected) begin
			$display("FAILED at %0t: %s, got %b expected %b", $time, what, actual, expected);
			errors++;
		end
	endtask

	task automatic report_result(input string name, input int start_errors);
		$display("%-12s done, %0d errors", name, errors - start_errors);
	endtask

	// bus released with no cycle running
	task automatic bus_idle();
		cpu_address = '0;
		cpu_as_n = 1'b1;
		cpu_rd = 1'b0;
		cpu_hwr = 1'b0;
		cpu_lwr = 1'b0;
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#1 reset = 1'b1;
		repeat (10) @(posedge clk);
		#1 reset = 1'b0;
	endtask

	// two-clock read with outputs sampled mid-cycle after the first edge
	task automatic bus_read(input logic [23:0] byte_addr, output logic sel,
			output cart_pkg::word_t data);
		@(posedge clk);
		#1;
		cpu_address = byte_addr[23:1];
		cpu_as_n = 1'b0;
		cpu_rd = 1'b1;
		@(posedge clk);
		@(negedge clk);
		sel = selmem;
		data = data_out;
		@(posedge clk);
		#1 bus_idle();
	endtask

	task automatic bus_write(input logic [23:0] byte_addr, input cart_pkg::word_t data,
			input logic hwr, input logic lwr);
		@(posedge clk);
		#1;
		cpu_address = byte_addr[23:1];
		cpu_as_n = 1'b0;
		data_in = data;
		cpu_hwr = hwr;
		cpu_lwr = lwr;
		@(posedge clk);
		#1 bus_idle();
	endtask

	task automatic reg_write(input cart_pkg::reg_addr_t idx, input cart_pkg::word_t data);
		@(posedge clk);
		#1;
		reg_address = idx;
		reg_data = data;
		@(posedge clk);
	endtask

	task automatic press_freeze();
		@(posedge clk);
		#1 freeze = 1'b1;
		@(posedge clk);
		#1 freeze = 1'b0;
	endtask

	// looks for int7 on each falling edge up to the limit
	task automatic wait_int7(input int limit, output logic seen);
		seen = 1'b0;
		for (int i = 0; i < limit && !seen; i++) begin
			@(negedge clk);
			if (int7)
				seen = 1'b1;
		end
	endtask

	// bootloader low-byte write into the rom half
	task automatic enable_cartridge();
		boot = 1'b1;
		bus_write(24'h400010, 16'h00a5, 1'b0, 1'b1);
		boot = 1'b0;
	endtask

	// vector fetch ack and overlay drop before the mode write that resumes
	task automatic leave_monitor(input cart_pkg::ar_mode_t new_mode);
		logic sel;
		cart_pkg::word_t data;
		bus_read(24'hffffff, sel, data);
		bus_write(24'h400006, 16'h0000, 1'b1, 1'b1);
		bus_write(24'h400000, {14'b0, new_mode}, 1'b0, 1'b1);
	endtask

	task automatic test_enable();
		int start;
		logic sel;
		cart_pkg::word_t data;
		start = errors;
		check_bit(aron, 1'b0, "aron after reset");
		check_bit(int7, 1'b0, "int7 after reset");
		check_bit(ovr, 1'b0, "ovr after reset");
		bus_read(24'h400010, sel, data);
		check_bit(sel, 1'b0, "selmem for rom while disabled");
		enable_cartridge();
		check_bit(aron, 1'b1, "aron after boot write");
		bus_read(24'h400000, sel, data);
		check_word(data, {14'b0, `STATUS_IDLE}, "status after reset");
		bus_read(24'h400010, sel, data);
		check_bit(sel, 1'b1, "selmem for rom read");
		bus_read(24'h440000, sel, data);
		check_bit(sel, 1'b1, "selmem for ram read");
		bus_read(24'h44f000, sel, data);
		check_bit(sel, 1'b0, "selmem for shadow read");
		report_result("enable", start);
	endtask

	task automatic test_freeze();
		int start;
		logic sel;
		logic seen;
		cart_pkg::word_t data;
		start = errors;
		press_freeze();
		wait_int7(2, seen);
		check_bit(seen, 1'b1, "int7 after freeze press");
		bus_read(24'h400000, sel, data);
		check_word(data, {14'b0, `STATUS_FREEZE}, "status after freeze");
		bus_read(24'hffffff, sel, data);
		check_bit(int7, 1'b0, "int7 after acknowledge");
		check_bit(ovr, 1'b1, "ovr after acknowledge");
		// level 7 autovector fetched from the cartridge through the overlay
		bus_read(24'h00007c, sel, data);
		check_bit(sel, 1'b1, "selmem for vector read under overlay");
		bus_write(24'h400006, 16'h0000, 1'b1, 1'b1);
		check_bit(ovr, 1'b0, "ovr after overlay clear write");
		bus_read(24'h00007c, sel, data);
		check_bit(sel, 1'b0, "selmem for chip read after overlay clear");
		bus_write(24'h400000, 16'h0000, 1'b0, 1'b1);
		press_freeze();
		wait_int7(2, seen);
		check_bit(seen, 1'b1, "int7 after monitor exit and new press");
		report_result("freeze", start);
	endtask

	task automatic test_reset_probe();
		int start;
		logic sel;
		logic seen;
		cart_pkg::word_t data;
		start = errors;
		apply_reset();
		enable_cartridge();
		check_bit(int7, 1'b0, "int7 before reset probe");
		bus_read(24'h000008, sel, data);
		wait_int7(2, seen);
		check_bit(seen, 1'b1, "int7 on first reset probe");
		leave_monitor(`MODE_RESET);
		// probe flag is spent after the first acknowledge
		bus_read(24'h000008, sel, data);
		wait_int7(4, seen);
		check_bit(seen, 1'b0, "int7 on second reset probe");
		report_result("reset_probe", start);
	endtask

	task automatic test_breakpoint();
		int start;
		logic sel;
		logic seen;
		cart_pkg::word_t data;
		start = errors;
		bus_read(24'h000200, sel, data);
		bus_read(24'hbfe001, sel, data);
		wait_int7(2, seen);
		check_bit(seen, 1'b1, "int7 on breakpoint");
		bus_read(24'h400000, sel, data);
		check_word(data, {14'b0, `STATUS_BREAK}, "status after breakpoint");
		leave_monitor(2'b00);
		// breakpoints now disabled
		bus_read(24'h000200, sel, data);
		bus_read(24'hbfe001, sel, data);
		wait_int7(4, seen);
		check_bit(seen, 1'b0, "int7 with breakpoints disabled");
		report_result("breakpoint", start);
	endtask

	task automatic test_shadow();
		int start;
		logic sel;
		cart_pkg::word_t data;
		cart_pkg::reg_addr_t idx;
		start = errors;
		for (int i = 0; i < 16; i++) begin
			idx = 8'(i * 17 + 3);
			shadow_exp[i] = cart_pkg::word_t'($random(seed));
			reg_write(idx, shadow_exp[i]);
		end
		for (int i = 0; i < 16; i++) begin
			idx = 8'(i * 17 + 3);
			bus_read(24'h44f000 + {15'b0, idx, 1'b0}, sel, data);
			check_word(data, shadow_exp[i], "shadow readback");
			check_bit(sel, 1'b0, "selmem on shadow readback");
		end
		report_result("shadow", start);
	endtask

	initial begin
		seed = 38163;
		errors = 0;
		checks = 0;
		cycles = 0;
		clk = 1'b0;
		reset = 1'b1;
		bus_idle();
		dbr = 1'b0;
		boot = 1'b0;
		data_in = '0;
		freeze = 1'b0;
		reg_address = '0;
		reg_data = '0;
		apply_reset();
		test_enable();
		test_freeze();
		test_reset_probe();
		test_breakpoint();
		test_shadow();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* source/action_replay_top.sv */
// freeze cartridge top level joining decoder, freeze control, breakpoint and shadow
`timescale 1ns/100ps

module action_replay_top (
	input logic clk,
	input logic reset,
	input cart_pkg::cpu_addr_t cpu_address,
	input logic cpu_as_n,
	input logic cpu_rd,
	input logic cpu_hwr,
	input logic cpu_lwr,
	input logic dbr,
	input logic boot,
	input cart_pkg::word_t data_in,
	input logic freeze,
	input cart_pkg::reg_addr_t reg_address,
	input cart_pkg::word_t reg_data,
	output cart_pkg::word_t data_out,
	output logic selmem,
	output logic ovr,
	output logic int7,
	output logic aron
);

	cart_bus_if bus ();

	logic sel_rom;
	logic sel_mode;
	logic sel_status;
	logic sel_custom;
	logic active;
	logic break_req;
	cart_pkg::ar_mode_t mode;
	cart_pkg::word_t status_out;
	cart_pkg::word_t custom_out;

	// pins onto the bus bundle
	assign bus.cpu_address = cpu_address;
	assign bus.cpu_as_n = cpu_as_n;
	assign bus.cpu_rd = cpu_rd;
	assign bus.cpu_hwr = cpu_hwr;
	assign bus.cpu_lwr = cpu_lwr;
	assign bus.dbr = dbr;
	assign bus.boot = boot;

	cart_decoder u_decoder (
		.bus(bus.monitor), .aron(aron), .ram_ovl(ovr), .sel_rom(sel_rom),
		.sel_mode(sel_mode), .sel_status(sel_status), .sel_custom(sel_custom),
		.selmem(selmem)
	);

	freeze_control u_freeze (
		.clk(clk), .reset(reset), .bus(bus.monitor), .freeze(freeze),
		.break_req(break_req), .sel_rom(sel_rom), .sel_mode(sel_mode),
		.sel_status(sel_status), .data_in(data_in), .aron(aron), .int7(int7),
		.ram_ovl(ovr), .active(active), .mode(mode), .status_out(status_out)
	);

	breakpoint_watch u_break (
		.clk(clk), .reset(reset), .bus(bus.monitor), .active(active),
		.aron(aron), .mode(mode), .break_req(break_req)
	);

	// shadow index is the low word address bits, $44f000 maps to register 0
	register_shadow u_shadow (
		.clk(clk), .reg_address(reg_address), .reg_data(reg_data),
		.cpu_index(cpu_address[8:1]), .sel_custom(sel_custom), .custom_out(custom_out)
	);

	// each read source is zero unless selected
	assign data_out = status_out | custom_out;

endmodule

/* cartridge/register_shadow.sv */
// custom chip register shadow memory written from the register bus
`timescale 1ns/100ps

module register_shadow (
	input logic clk,
	input cart_pkg::reg_addr_t reg_address,
	input cart_pkg::word_t reg_data,
	input cart_pkg::reg_addr_t cpu_index,
	input logic sel_custom,
	output cart_pkg::word_t custom_out
);

	// one word per custom register, $dff000-$dff1fe
	cart_pkg::word_t shadow_mem [256];
	// read address register so the array maps onto block ram
	cart_pkg::reg_addr_t cpu_index_q;

	// every register bus cycle lands here, cpu and dma alike
	always_ff @(posedge clk) begin
		shadow_mem[reg_address] <= reg_data;
	end

	always_ff @(posedge clk) begin
		cpu_index_q <= cpu_index;
	end

	// zero when not selected so the top can OR the read paths
	assign custom_out = sel_custom ? shadow_mem[cpu_index_q] : '0;

endmodule

/* cartridge/breakpoint_watch.sv */
// breakpoint watch for a CIA-A access made by code in the low program region
`timescale 1ns/100ps
`include "cart_consts.svh"

module breakpoint_watch (
	input logic clk,
	input logic reset,
	cart_bus_if.monitor bus,
	input logic active,
	input logic aron,
	input cart_pkg::ar_mode_t mode,
	output logic break_req
);

	logic as_n_del;
	logic cur_low;
	logic low_hit;

	// cur_low follows the running cycle, low_hit holds the finished one
	always_ff @(posedge clk) begin
		if (reset) begin
			as_n_del <= 1'b1;
			cur_low <= 1'b0;
			low_hit <= 1'b0;
		end else begin
			as_n_del <= bus.cpu_as_n;
			if (!bus.cpu_as_n)
				cur_low <= (bus.cpu_address[23:10] == `LOW_REGION_TOP);
			// strobe released, cycle complete
			if (bus.cpu_as_n && !as_n_del)
				low_hit <= cur_low;
		end
	end

	// TST.B $bfe001 fetched from $000-$3ff, then the data access itself
	assign break_req = !active && aron && mode[1] && low_hit && !bus.cpu_as_n
		&& (bus.cpu_address == `BREAK_ADDR);

endmodule

/* cartridge/freeze_control.sv */
// freeze control with enable flag, int7 FSM, overlay, mode and status registers
`timescale 1ns/100ps
`include "cart_consts.svh"

module freeze_control (
	input logic clk,
	input logic reset,
	cart_bus_if.monitor bus,
	input logic freeze,
	input logic break_req,
	input logic sel_rom,
	input logic sel_mode,
	input logic sel_status,
	input cart_pkg::word_t data_in,
	output logic aron,
	output logic int7,
	output logic ram_ovl,
	output logic active,
	output cart_pkg::ar_mode_t mode,
	output cart_pkg::word_t status_out
);

	cart_pkg::fc_state_t state;
	cart_pkg::ar_status_t status;
	logic freeze_del;
	logic after_reset;
	logic freeze_req;
	logic reset_req;
	logic int7_req;
	logic int7_ack;
	logic mode_wr;
	logic ovl_clr;

	// button edge, ignored while the monitor already runs
	assign freeze_req = freeze && !freeze_del && !active;
	// first touch of the reset vector area after a reset
	assign reset_req = aron && after_reset && !bus.cpu_as_n
		&& (bus.cpu_address == `RESET_PROBE_ADDR);
	assign int7_req = !bus.boot && aron && (freeze_req || reset_req || break_req);
	// autovector fetch, all address lines high
	assign int7_ack = (&bus.cpu_address) && !bus.cpu_as_n && bus.cpu_rd;
	assign mode_wr = sel_mode && (bus.cpu_hwr || bus.cpu_lwr);
	assign ovl_clr = sel_rom && (bus.cpu_address[18:1] == `OVL_CLEAR_OFFSET)
		&& (bus.cpu_hwr || bus.cpu_lwr);

	assign int7 = (state == cart_pkg::FC_PENDING);
	assign status_out = sel_status ? {14'b0, status} : '0;

	always_ff @(posedge clk) begin
		freeze_del <= freeze;
		if (reset) begin
			aron <= 1'b0;
			after_reset <= 1'b1;
			state <= cart_pkg::FC_IDLE;
			ram_ovl <= 1'b0;
			active <= 1'b0;
			mode <= `MODE_RESET;
			status <= `STATUS_IDLE;
		end else begin
			// bootloader writing the rom image turns the cartridge on
			if (bus.boot && bus.cpu_lwr && !bus.cpu_address[18]
					&& (bus.cpu_address[23:19] == `CART_BASE_TOP))
				aron <= 1'b1;
			if (freeze_req)
				status <= `STATUS_FREEZE;
			else if (break_req)
				status <= `STATUS_BREAK;
			if (mode_wr) begin
				// monitor exit
				active <= 1'b0;
				state <= cart_pkg::FC_IDLE;
				if (bus.cpu_lwr)
					mode <= data_in[1:0];
			end else if (state == cart_pkg::FC_IDLE && int7_req) begin
				state <= cart_pkg::FC_PENDING;
			end else if (state == cart_pkg::FC_PENDING && int7_ack) begin
				state <= cart_pkg::FC_STOPPED;
				active <= 1'b1;
				ram_ovl <= 1'b1;
				after_reset <= 1'b0;
			end
			// monitor drops the overlay once the vector is fetched
			if (ovl_clr)
				ram_ovl <= 1'b0;
		end
	end

endmodule

/* cartridge/cart_decoder.sv */
// cartridge window decoder producing register selects and the external memory select
`timescale 1ns/100ps
`include "cart_consts.svh"

module cart_decoder (
	cart_bus_if.monitor bus,
	input logic aron,
	input logic ram_ovl,
	output logic sel_rom,
	output logic sel_mode,
	output logic sel_status,
	output logic sel_custom,
	output logic selmem
);

	logic sel_cart;
	logic shadow_page;
	logic sel_ram;
	logic sel_ovl;

	// whole window $400000-$47ffff, hidden while the chipset owns the bus
	assign sel_cart = aron && !bus.dbr && (bus.cpu_address[23:19] == `CART_BASE_TOP);

	// shadow page inside the ram half
	assign shadow_page = bus.cpu_address[18] && (bus.cpu_address[17:9] == `SHADOW_PAGE);

	// rom half, first two words belong to the mode and status registers
	assign sel_rom = sel_cart && !bus.cpu_address[18] && (|bus.cpu_address[17:2]);

	// work ram is the upper half minus the shadow page
	assign sel_ram = sel_cart && bus.cpu_address[18] && !shadow_page;

	// shadow readback, cpu writes go to the real chip registers instead
	assign sel_custom = sel_cart && shadow_page && bus.cpu_rd;

	// mode register at $400000/1
	assign sel_mode = sel_cart && !(|bus.cpu_address[18:1]);

	// status register mirrored over $400000-$400003, read only
	assign sel_status = sel_cart && !(|bus.cpu_address[18:2]) && bus.cpu_rd;

	// rom shows up over chip ram for the int7 vector fetch
	// reads only, writes still reach chip ram
	assign sel_ovl = ram_ovl && (bus.cpu_address[23:19] == 5'b00000) && bus.cpu_rd;

	// external memory select
	// rom is writable only while the bootloader loads the image
	assign selmem = (sel_rom && bus.boot)
		|| (sel_rom && bus.cpu_rd)
		|| sel_ram
		|| sel_ovl;

endmodule

/* common/cart_bus_if.sv */
// cpu bus cycle bundle shared by the cartridge decoder and bus watchers
`timescale 1ns/100ps

interface cart_bus_if;

	// word address and strobe of the current cycle
	cart_pkg::cpu_addr_t cpu_address;
	logic cpu_as_n;
	// read, upper byte write and lower byte write qualifiers
	logic cpu_rd;
	logic cpu_hwr;
	logic cpu_lwr;
	// chipset owns the bus
	logic dbr;
	// bootloader still running, rom image being loaded
	logic boot;

	// top level drives the bundle from its pins
	modport source (
		output cpu_address, cpu_as_n, cpu_rd, cpu_hwr, cpu_lwr, dbr, boot
	);

	// blocks that only observe the bus
	modport monitor (
		input cpu_address, cpu_as_n, cpu_rd, cpu_hwr, cpu_lwr, dbr, boot
	);

endinterface

/* common/cart_pkg.sv */
// freeze cartridge shared types for bus words, registers and the interrupt FSM
package cart_pkg;

	// cpu word address, byte lane bit 0 is not on the bus
	typedef logic [23:1] cpu_addr_t;

	// 16-bit data word on the cpu and register buses
	typedef logic [15:0] word_t;

	// custom chip register word index
	typedef logic [7:0] reg_addr_t;

	// mode register
	// bit 1 arms the breakpoint circuit
	// bit 0 is stored for the monitor but has no hardware effect
	typedef logic [1:0] ar_mode_t;

	// status code read back by the monitor ROM
	typedef logic [1:0] ar_status_t;

	// interrupt FSM
	// FC_IDLE     waiting for a freeze, reset probe or breakpoint request
	// FC_PENDING  int7 asserted, waiting for the cpu acknowledge cycle
	// FC_STOPPED  monitor running until it writes the mode register
	typedef enum logic [1:0] {
		FC_IDLE,
		FC_PENDING,
		FC_STOPPED
	} fc_state_t;

endpackage

/* common/cart_consts.svh */
// freeze cartridge address map constants and register reset values
`ifndef CART_CONSTS_SVH
`define CART_CONSTS_SVH

// address bits 23:19 of the cartridge window $400000-$47ffff
`define CART_BASE_TOP 5'b01000

// address bits 17:9 of the custom register shadow, $44f000-$44f1ff
`define SHADOW_PAGE 9'b0_0111_1000

// word address of the watched CIA-A byte $bfe001
`define BREAK_ADDR 23'h5F_F000

// word address of byte $8, first touched after a cpu reset
`define RESET_PROBE_ADDR 23'h00_0004

// address bits 23:10 are zero for the low program region $000-$3ff
`define LOW_REGION_TOP 14'h0000

// mode and status values
`define MODE_RESET 2'b11
`define STATUS_IDLE 2'b11
`define STATUS_FREEZE 2'b00
`define STATUS_BREAK 2'b01

// rom word index 3, a write to $400006 drops the chip ram overlay
`define OVL_CLEAR_OFFSET 18'h0_0003

`endif
